// File: filelist.f
rtl/color_pkg.sv
rtl/frame_scanner.sv
rtl/pixel_filter.sv
rtl/column_histogram.sv
rtl/centroid_decider.sv
rtl/color_proc.sv
verification/tb_clock_gen.sv
verification/tb_color_proc.sv

// File: rtl/centroid_decider.sv
//==========================================================================
// Centroid decider
// turns the histogram counts into an led centroid and a proximity level,
// both captured at frame end with a one cycle new_centroid strobe
//==========================================================================
`timescale 1ns/100ps

module centroid_decider (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_end,
  input  color_pkg::bin_cnt_t  bin0_cnt,
  input  color_pkg::bin_cnt_t  bin7_cnt,
  input  color_pkg::half_cnt_t bins01_cnt,
  input  color_pkg::half_cnt_t bins012_cnt,
  input  color_pkg::half_cnt_t left_cnt,
  input  color_pkg::half_cnt_t right_cnt,
  input  color_pkg::half_cnt_t bins567_cnt,
  input  color_pkg::half_cnt_t bins67_cnt,
  input  color_pkg::cnt_t      total_cnt,
  output color_pkg::centroid_t centroid,
  output color_pkg::prox_t     proximity,
  output logic                 new_centroid
);

  import color_pkg::*;

  half_cnt_t half_cnt;       // total / 2
  half_cnt_t tol_cnt;        // total / 16, centred band
  half_cnt_t abs_diff;       // |left - right|
  logic      more_left;
  centroid_t centroid_cmb;
  prox_t     prox_cmb;

  assign half_cnt  = half_cnt_t'(total_cnt >> 1);
  assign tol_cnt   = half_cnt_t'(total_cnt >> 4);
  assign more_left = (left_cnt > right_cnt);
  assign abs_diff  = more_left ? (left_cnt - right_cnt) : (right_cnt - left_cnt);

  // search from the outer edge inwards, first hit wins
  always_comb begin
    centroid_cmb = '0;
    if (total_cnt <= cnt_t'(min_color_pxls)) begin
      centroid_cmb = '0;                       // too few pixels, nothing seen
    end else if (abs_diff < tol_cnt) begin
      centroid_cmb[4:3] = 2'b11;               // balanced, both middle leds
    end else if (more_left) begin
      if (half_cnt_t'(bin0_cnt) >= half_cnt) begin
        centroid_cmb[0] = 1'b1;
      end else if (bins01_cnt >= half_cnt) begin
        centroid_cmb[1] = 1'b1;
      end else if (bins012_cnt >= half_cnt) begin
        centroid_cmb[2] = 1'b1;
      end else if (left_cnt > half_cnt) begin
        centroid_cmb[3] = 1'b1;
      end
    end else begin
      // mirror image on the right side
      if (half_cnt_t'(bin7_cnt) >= half_cnt) begin
        centroid_cmb[7] = 1'b1;
      end else if (bins67_cnt >= half_cnt) begin
        centroid_cmb[6] = 1'b1;
      end else if (bins567_cnt >= half_cnt) begin
        centroid_cmb[5] = 1'b1;
      end else if (right_cnt > half_cnt) begin
        centroid_cmb[4] = 1'b1;
      end
    end
  end

  // more pixels means a closer object
  always_comb begin
    prox_cmb = '0;
    for (int i = 0; i < prox_levels; i++) begin
      if (total_cnt >= prox_limits[i]) prox_cmb = prox_cmb + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      centroid     <= '0;
      proximity    <= '0;
      new_centroid <= 1'b0;
    end else begin
      new_centroid <= frame_end;   // one pulse per frame
      if (frame_end) begin
        centroid  <= centroid_cmb;
        proximity <= prox_cmb;
      end
    end
  end

  // frame_end from the scanner must be a single cycle
  a_strobe_width: assert property (@(posedge clk) disable iff (rst)
    new_centroid |=> !new_centroid)
    else $error("new_centroid held longer than one cycle");

endmodule

// File: rtl/color_pkg.sv
//==========================================================================
// Colour processing shared definitions
// frame geometry, pixel layout, histogram widths, proximity thresholds
// and the colour filter modes
//==========================================================================

package color_pkg;

  // default frame size, qqvga
  localparam int img_cols = 160;
  localparam int img_rows = 120;
  localparam int img_pxls = img_cols * img_rows;  // 19200

  typedef logic [14:0] addr_t;   // pixel address
  typedef logic [7:0]  col_t;    // column index
  typedef logic [6:0]  row_t;    // row index
  typedef logic [11:0] pxl_t;    // rgb444 pixel

  // msb of each colour field in a pixel
  localparam int red_msb   = 11;
  localparam int green_msb = 7;
  localparam int blue_msb  = 3;

  // inner frame is 128 x 104, 16 columns and 8 rows trimmed at each side
  localparam int in_col_first = 16;
  localparam int in_col_last  = 143;
  localparam int in_row_first = 8;
  localparam int in_row_last  = 111;

  localparam int hist_bins = 8;
  localparam int bin_cols  = 16;   // inner columns per bin

  typedef logic [2:0]  bin_t;
  typedef logic [10:0] bin_cnt_t;   // max 104 * 16 = 1664
  typedef logic [13:0] cnt_t;       // max 13312, whole inner frame
  typedef logic [12:0] half_cnt_t;  // half frame and grouped bins

  typedef logic [7:0] centroid_t;   // one bit per led
  typedef logic [2:0] prox_t;       // 0 far .. 7 close

  // fewer pixels than this is treated as noise
  localparam int min_color_pxls = 128;

  // proximity level is the number of limits reached
  localparam int prox_levels = 7;
  localparam cnt_t prox_limits [prox_levels] = '{
    14'd32, 14'd64, 14'd128, 14'd256, 14'd512, 14'd1024, 14'd1536
  };

  // encoding is the {red, green, blue} msb pattern that passes
  typedef enum logic [2:0] {
    filt_none    = 3'b000,
    filt_red     = 3'b100,
    filt_green   = 3'b010,
    filt_blue    = 3'b001,
    filt_yellow  = 3'b110,
    filt_magenta = 3'b101,
    filt_cyan    = 3'b011,
    filt_white   = 3'b111
  } filter_mode_t;

endpackage

// File: rtl/color_proc.sv
//==========================================================================
// Colour processing top
// scans a stored frame, filters it by colour and reports the object
// centroid and proximity once per frame
//==========================================================================
`timescale 1ns/100ps

module color_proc #(
  parameter int img_cols = color_pkg::img_cols,
  parameter int img_rows = color_pkg::img_rows
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    proc_ctrl,      // filter select button
  input  color_pkg::pxl_t         orig_pxl,       // from source memory
  output color_pkg::addr_t        orig_addr,
  output logic                    proc_we,
  output color_pkg::pxl_t         proc_pxl,       // to output memory
  output color_pkg::addr_t        proc_addr,
  output color_pkg::centroid_t    centroid,
  output logic                    new_centroid,
  output color_pkg::prox_t        proximity,
  output color_pkg::filter_mode_t rgbfilter
);

  import color_pkg::*;

  logic      frame_end;
  logic      in_frame;
  logic      pass;
  bin_t      hist_bin;
  bin_cnt_t  bin0_cnt;
  bin_cnt_t  bin7_cnt;
  half_cnt_t bins01_cnt;
  half_cnt_t bins012_cnt;
  half_cnt_t left_cnt;
  half_cnt_t right_cnt;
  half_cnt_t bins567_cnt;
  half_cnt_t bins67_cnt;
  cnt_t      total_cnt;

  frame_scanner #(.img_cols(img_cols), .img_rows(img_rows)) i_scanner (
    .clk, .rst, .orig_addr, .proc_addr, .proc_we, .frame_end, .in_frame, .hist_bin
  );

  pixel_filter i_filter (
    .clk, .rst, .proc_ctrl, .orig_pxl, .proc_pxl, .pass, .rgbfilter
  );

  column_histogram i_histogram (
    .clk, .rst, .frame_end, .in_frame, .pass, .hist_bin,
    .bin0_cnt, .bin7_cnt, .bins01_cnt, .bins012_cnt, .left_cnt, .right_cnt,
    .bins567_cnt, .bins67_cnt, .total_cnt
  );

  centroid_decider i_decider (
    .clk, .rst, .frame_end,
    .bin0_cnt, .bin7_cnt, .bins01_cnt, .bins012_cnt, .left_cnt, .right_cnt,
    .bins567_cnt, .bins67_cnt, .total_cnt,
    .centroid, .proximity, .new_centroid
  );

endmodule

// File: rtl/column_histogram.sv
//==========================================================================
// Column histogram
// counts passing inner frame pixels per column bin and in the grouped
// ranges used for the centroid, cleared at every frame end
//==========================================================================
`timescale 1ns/100ps

module column_histogram (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_end,
  input  logic                 in_frame,
  input  logic                 pass,
  input  color_pkg::bin_t      hist_bin,
  output color_pkg::bin_cnt_t  bin0_cnt,
  output color_pkg::bin_cnt_t  bin7_cnt,
  output color_pkg::half_cnt_t bins01_cnt,
  output color_pkg::half_cnt_t bins012_cnt,
  output color_pkg::half_cnt_t left_cnt,
  output color_pkg::half_cnt_t right_cnt,
  output color_pkg::half_cnt_t bins567_cnt,
  output color_pkg::half_cnt_t bins67_cnt,
  output color_pkg::cnt_t      total_cnt
);

  import color_pkg::*;

  localparam int half_bins = hist_bins / 2;

  bin_cnt_t hist [hist_bins];   // per bin counts
  logic     count_en;

  assign count_en = in_frame & pass;

  // grouped sums kept as counters instead of adder trees on the bins
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < hist_bins; i++) begin
        hist[i] <= '0;
      end
      bins01_cnt  <= '0;
      bins012_cnt <= '0;
      left_cnt    <= '0;
      right_cnt   <= '0;
      bins567_cnt <= '0;
      bins67_cnt  <= '0;
      total_cnt   <= '0;
    end else if (frame_end) begin   // clear wins over counting
      for (int i = 0; i < hist_bins; i++) begin
        hist[i] <= '0;
      end
      bins01_cnt  <= '0;
      bins012_cnt <= '0;
      left_cnt    <= '0;
      right_cnt   <= '0;
      bins567_cnt <= '0;
      bins67_cnt  <= '0;
      total_cnt   <= '0;
    end else if (count_en) begin
      hist[hist_bin] <= hist[hist_bin] + 1'b1;
      total_cnt      <= total_cnt + 1'b1;
      if (hist_bin <= bin_t'(1)) bins01_cnt <= bins01_cnt + 1'b1;       // 0,1
      if (hist_bin <= bin_t'(2)) bins012_cnt <= bins012_cnt + 1'b1;     // 0..2
      if (hist_bin < bin_t'(half_bins)) begin
        left_cnt <= left_cnt + 1'b1;                                     // 0..3
      end else begin
        right_cnt <= right_cnt + 1'b1;                                   // 4..7
      end
      if (hist_bin >= bin_t'(5)) bins567_cnt <= bins567_cnt + 1'b1;     // 5..7
      if (hist_bin >= bin_t'(6)) bins67_cnt <= bins67_cnt + 1'b1;       // 6,7
    end
  end

  // only the edge bins feed the decision
  assign bin0_cnt = hist[0];
  assign bin7_cnt = hist[hist_bins-1];

  a_total_mono: assert property (@(posedge clk) disable iff (rst)
    !frame_end |=> (total_cnt >= $past(total_cnt)))
    else $error("pixel total dropped inside a frame");

endmodule

// File: rtl/frame_scanner.sv
//==========================================================================
// Frame scanner
// raster address, column and row counters, write address delay and the
// inner frame window with its histogram bin
//==========================================================================
`timescale 1ns/100ps

module frame_scanner #(
  parameter int img_cols = color_pkg::img_cols,
  parameter int img_rows = color_pkg::img_rows
) (
  input  logic             clk,
  input  logic             rst,
  output color_pkg::addr_t orig_addr,
  output color_pkg::addr_t proc_addr,
  output logic             proc_we,
  output logic             frame_end,
  output logic             in_frame,
  output color_pkg::bin_t  hist_bin
);

  import color_pkg::*;

  localparam int frame_pxls = img_cols * img_rows;
  localparam int bin_shift  = $clog2(bin_cols);

  addr_t pxl_cnt;     // read address
  col_t  col;         // column of pxl_cnt
  col_t  col_rg;      // column of the pixel now on orig_pxl
  row_t  row;
  row_t  row_rg;
  col_t  col_in;      // column relative to the inner frame
  col_t  bin_full;    // bin number before truncation
  logic  end_ln;

  assign frame_end = (pxl_cnt == addr_t'(frame_pxls - 1));
  assign end_ln    = (col == col_t'(img_cols - 1));
  assign orig_addr = pxl_cnt;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pxl_cnt   <= '0;
      proc_addr <= '0;
      proc_we   <= 1'b0;
      col       <= '0;
      row       <= '0;
      col_rg    <= '0;
      row_rg    <= '0;
    end else begin
      proc_we   <= 1'b1;
      proc_addr <= pxl_cnt;      // memory returns data one cycle late
      col_rg    <= col;          // line up position with returning pixel
      row_rg    <= row;
      if (frame_end) begin
        pxl_cnt <= '0;
      end else begin
        pxl_cnt <= pxl_cnt + 1'b1;
      end
      if (end_ln) begin
        col <= '0;
      end else begin
        col <= col + 1'b1;
      end
      if (frame_end) begin
        row <= '0;
      end else if (end_ln) begin
        row <= row + 1'b1;
      end
    end
  end

  assign in_frame = (col_rg >= col_t'(in_col_first)) && (col_rg <= col_t'(in_col_last)) &&
                    (row_rg >= row_t'(in_row_first)) && (row_rg <= row_t'(in_row_last));

  // out of the window the bin value is don't care
  assign col_in   = col_rg - col_t'(in_col_first);
  assign bin_full = col_in >> bin_shift;   // divide by bin_cols
  assign hist_bin = bin_t'(bin_full);

  // window bounds and bin width must agree with the bin count
  a_bin_range: assert property (@(posedge clk) disable iff (rst)
    in_frame |-> (bin_full < col_t'(hist_bins)))
    else $error("inner frame column maps outside the histogram");

endmodule

// File: rtl/pixel_filter.sv
//==========================================================================
// Pixel filter
// proc_ctrl edge steps the colour mode, each pixel is tested against the
// mode and passes unchanged or becomes black
//==========================================================================
`timescale 1ns/100ps

module pixel_filter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    proc_ctrl,
  input  color_pkg::pxl_t         orig_pxl,
  output color_pkg::pxl_t         proc_pxl,
  output logic                    pass,
  output color_pkg::filter_mode_t rgbfilter
);

  import color_pkg::*;

  logic         ctrl_meta;     // first sync stage
  logic         ctrl_sync;     // second sync stage
  logic         ctrl_sync_d;   // previous synced value
  logic         ctrl_rise;     // registered rising edge
  logic [2:0]   pxl_msbs;
  filter_mode_t next_mode;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_meta   <= 1'b0;
      ctrl_sync   <= 1'b0;
      ctrl_sync_d <= 1'b0;
      ctrl_rise   <= 1'b0;
    end else begin
      ctrl_meta   <= proc_ctrl;   // async button input
      ctrl_sync   <= ctrl_meta;
      ctrl_sync_d <= ctrl_sync;
      ctrl_rise   <= ctrl_sync & ~ctrl_sync_d;
    end
  end

  // mode sequence, wraps back to no filter
  always_comb begin
    case (rgbfilter)
      filt_none:    next_mode = filt_red;
      filt_red:     next_mode = filt_green;
      filt_green:   next_mode = filt_blue;
      filt_blue:    next_mode = filt_yellow;
      filt_yellow:  next_mode = filt_magenta;
      filt_magenta: next_mode = filt_cyan;
      filt_cyan:    next_mode = filt_white;
      filt_white:   next_mode = filt_none;
      default:      next_mode = filt_none;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rgbfilter <= filt_none;
    end else if (ctrl_rise) begin
      rgbfilter <= next_mode;
    end
  end

  assign pxl_msbs = {orig_pxl[red_msb], orig_pxl[green_msb], orig_pxl[blue_msb]};

  // exact msb match, no filter lets everything through
  assign pass     = (rgbfilter == filt_none) || (pxl_msbs == rgbfilter);
  assign proc_pxl = pass ? orig_pxl : '0;   // failing pixel goes black

  // a mode step needs a rise of the synchronised button two cycles earlier
  a_mode_on_edge: assert property (@(posedge clk) disable iff (rst)
    (rgbfilter != $past(rgbfilter)) |-> ($past(ctrl_sync, 2) && !$past(ctrl_sync, 3)))
    else $error("filter mode changed without a proc_ctrl edge");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the colour processing testbench with Verilator
set -e
cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_color_proc -f filelist.f -o sim_color_proc

# the simulator exit code is not used, the log decides
./obj_dir/sim_color_proc > "$log" 2>&1 || true
cat "$log"

if grep -q "Simulation failed" "$log"; then
  echo "run_sim: FAILED"
  exit 1
fi
if ! grep -q "Simulation passed" "$log"; then
  echo "run_sim: no verdict in $log"
  exit 1
fi
echo "run_sim: PASSED"

// File: verification/tb_clock_gen.sv
//==========================================================================
// Testbench clock and reset
// 40 ns clock, reset held high for the first 10 cycles
//==========================================================================
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b1;               // first falling edge lands after reset is up
    forever #20 clk = ~clk;   // 25 MHz
  end

  initial begin
    rst = 1'b0;
    #5 rst = 1'b1;            // clean rising edge for the async reset
    repeat (10) @(posedge clk);
    #2 rst = 1'b0;            // release just after an edge
  end

endmodule

// File: verification/tb_color_proc.sv
//==========================================================================
// Colour processing testbench
// feeds synthetic frames to the DUT and checks addressing, filtering,
// strobe timing and the centroid and proximity of every stimulus row
//==========================================================================
`timescale 1ns/100ps

module tb_color_proc;

  localparam int img_cols   = 160;
  localparam int img_rows   = 120;
  localparam int img_pxls   = img_cols * img_rows;
  localparam int n_rows     = 11;
  localparam int max_cycles = (n_rows * 2 + 3) * img_pxls;   // two frames a row plus margin

  typedef struct {
    int          pulses;   // proc_ctrl pulses before this row
    logic [2:0]  mode;     // expected filter mode, {r, g, b}
    logic [11:0] fg;       // rectangle colour
    int          col_lo;
    int          col_hi;
    int          row_lo;
    int          row_hi;
    logic [11:0] bg;       // background colour, msbs fail the mode
    logic [7:0]  cent;     // expected led centroid
    logic [2:0]  prox;     // expected proximity
  } stim_row_t;

  logic        clk;
  logic        rst;
  logic        proc_ctrl;
  logic [11:0] orig_pxl;
  logic [14:0] orig_addr;
  logic        proc_we;
  logic [11:0] proc_pxl;
  logic [14:0] proc_addr;
  logic [7:0]  centroid;
  logic        new_centroid;
  logic [2:0]  proximity;
  logic [2:0]  rgbfilter;

  stim_row_t   tbl [n_rows];
  int          cur_row;       // row whose picture the memory shows
  logic [31:0] lfsr;
  logic [11:0] next_pxl;
  int          read_addr;     // address latched by the image memory
  logic        mode_known;    // filter mode settled, pixel checks on
  logic [2:0]  exp_mode;
  int          cycle_cnt;
  int          fail_cnt;
  int          prev_addr;
  int          run_cycles;
  logic        strobe_prev;
  logic        strobe_seen;
  int          last_strobe;

  tb_clock_gen i_clk_gen (.clk, .rst);

  color_proc #(.img_cols(img_cols), .img_rows(img_rows)) i_dut (
    .clk, .rst, .proc_ctrl, .orig_pxl, .orig_addr, .proc_we, .proc_pxl, .proc_addr,
    .centroid, .new_centroid, .proximity, .rgbfilter
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // pixel after the colour filter, mode none passes all
  function automatic logic [11:0] expected_pixel(input logic [11:0] p, input logic [2:0] mode);
    if ((mode == 3'b000) || ({p[11], p[7], p[3]} == mode)) expected_pixel = p;
    else expected_pixel = 12'h000;
  endfunction

  // rectangle on a noisy background, noise never touches a colour msb
  task automatic make_pixel(input int addr, output logic [11:0] pxl);
    int          col;
    int          row;
    logic [11:0] noise;
    col   = addr % img_cols;
    row   = addr / img_cols;
    noise = '0;
    if (col >= tbl[cur_row].col_lo && col <= tbl[cur_row].col_hi &&
        row >= tbl[cur_row].row_lo && row <= tbl[cur_row].row_hi) begin
      pxl = tbl[cur_row].fg;
    end else begin
      for (int b = 0; b < 12; b++) begin
        if (b % 4 != 3) begin       // bits 3, 7, 11 are the msbs
          lfsr     = lfsr_next(lfsr);
          noise[b] = lfsr[0];
        end
      end
      pxl = tbl[cur_row].bg | noise;
    end
  endtask

  task automatic pulse_ctrl();
    proc_ctrl = 1'b1;              // two cycles high, seen by the synchroniser
    repeat (2) @(posedge clk);
    #2 proc_ctrl = 1'b0;
    repeat (2) @(posedge clk);
    #2;
  endtask

  task automatic wait_strobe();
    do begin
      @(negedge clk);
    end while (new_centroid !== 1'b1);
  endtask

  // image memory, one cycle read latency
  always @(posedge clk) begin
    #2;
    make_pixel(read_addr, next_pxl);
    orig_pxl = next_pxl;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("timeout: no verdict after %0d clock cycles", cycle_cnt);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // outputs are sampled mid cycle
  always @(negedge clk) begin
    read_addr = int'(orig_addr);
    if (rst) begin
      check("proc_we", 32'(proc_we), 32'h0);
      check("new_centroid", 32'(new_centroid), 32'h0);
      check("centroid", 32'(centroid), 32'h0);
      check("proximity", 32'(proximity), 32'h0);
      run_cycles = 0;
    end else begin
      if (run_cycles == 0) begin
        check("orig_addr", 32'(orig_addr), 32'h0);   // scan starts at pixel 0
      end else begin
        check("proc_we", 32'(proc_we), 32'h1);
        check("orig_addr", 32'(orig_addr), 32'((prev_addr + 1) % img_pxls));
        check("proc_addr", 32'(proc_addr), 32'(prev_addr));
      end
      prev_addr = int'(orig_addr);
      run_cycles++;
      if (mode_known) begin
        check("proc_pxl", 32'(proc_pxl), 32'(expected_pixel(orig_pxl, exp_mode)));
      end
      if (strobe_prev) check("new_centroid", 32'(new_centroid), 32'h0);   // one cycle wide
      if (new_centroid) begin
        if (strobe_seen) check("strobe_interval", 32'(cycle_cnt - last_strobe), 32'(img_pxls));
        last_strobe = cycle_cnt;
        strobe_seen = 1'b1;
      end
      strobe_prev = new_centroid;
    end
  end

  initial begin
    proc_ctrl   = 1'b0;
    orig_pxl    = '0;
    cur_row     = 0;
    lfsr        = 32'h4a1;
    read_addr   = 0;
    mode_known  = 1'b0;
    exp_mode    = 3'b000;
    cycle_cnt   = 0;
    fail_cnt    = 0;
    prev_addr   = 0;
    run_cycles  = 0;
    strobe_prev = 1'b0;
    strobe_seen = 1'b0;
    last_strobe = 0;
    // pulses mode    fg   col range  row range   bg      cent   prox
    tbl[0]  = '{0, 3'b000, 12'hfff,  16, 143,  8, 111, 12'h000, 8'h18, 3'd7};  // all pass
    tbl[1]  = '{1, 3'b100, 12'hf00,  20,  29, 20,  29, 12'h00f, 8'h00, 3'd2};  // 100 px, too few
    tbl[2]  = '{1, 3'b010, 12'h0f0,  64,  95, 20,  29, 12'h800, 8'h18, 3'd4};  // centred
    tbl[3]  = '{1, 3'b001, 12'h00f,  16,  31,  8,  27, 12'h080, 8'h01, 3'd4};
    tbl[4]  = '{1, 3'b110, 12'hff0,  24,  47, 30,  39, 12'h00f, 8'h02, 3'd3};
    tbl[5]  = '{1, 3'b101, 12'hf0f,  44,  59, 40,  49, 12'h088, 8'h04, 3'd3};
    tbl[6]  = '{1, 3'b011, 12'h0ff,  56,  95, 50,  59, 12'h800, 8'h08, 3'd4};
    tbl[7]  = '{1, 3'b111, 12'hfff, 128, 143, 60,  79, 12'h000, 8'h80, 3'd4};
    tbl[8]  = '{2, 3'b100, 12'hf00, 112, 135, 70,  79, 12'h0f0, 8'h40, 3'd3};  // wraps past none
    tbl[9]  = '{1, 3'b010, 12'h0f0, 100, 115, 80,  89, 12'hf00, 8'h20, 3'd3};
    tbl[10] = '{1, 3'b001, 12'h00f,  64, 103, 90,  99, 12'h0f0, 8'h10, 3'd4};
    @(negedge rst);
    for (int r = 0; r < n_rows; r++) begin
      cur_row = r;                 // new picture from the next pixel on
      @(posedge clk);
      #2 mode_known = 1'b0;
      repeat (tbl[r].pulses) pulse_ctrl();
      wait_strobe();               // frame with the mode change, discarded
      check("rgbfilter", 32'(rgbfilter), 32'(tbl[r].mode));
      @(posedge clk);
      #2;
      exp_mode   = tbl[r].mode;
      mode_known = 1'b1;
      wait_strobe();
      check("centroid", 32'(centroid), 32'(tbl[r].cent));
      check("proximity", 32'(proximity), 32'(tbl[r].prox));
    end
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
